// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= display_top_tb
FILELIST  ?= display_top.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== display_top.f ====
logic/display_pkg.sv
logic/cpu_bus_if.sv
logic/scan_if.sv
logic/display_timing.sv
logic/display_regs.sv
logic/frame_ram.sv
logic/frame_buffer.sv
logic/pixel_out.sv
logic/display_top.sv
verif/display_top_tb.sv

// ==== logic/cpu_bus_if.sv ====
// CPU accesses to video memory, passed from the register decode to the frame buffer
`timescale 1ns/100ps

interface cpu_bus_if;

    // One cycle strobe for an access inside the frame buffer window
    logic sel;
    logic [13:1] addr;
    logic wr_en;
    logic [15:0] wdata;
    logic [1:0] bytesel;
    // Registered RAM output, valid the cycle after sel
    logic [15:0] rdata;

    modport host (
        output sel, addr, wr_en, wdata, bytesel,
        input rdata
    );

    modport ram (
        input sel, addr, wr_en, wdata, bytesel,
        output rdata
    );

endinterface

// ==== logic/display_pkg.sv ====
// Raster timing, address map and register definitions shared by the display blocks
package display_pkg;

    // Horizontal timing in pixel clocks
    localparam int h_active = 640;
    localparam int h_front = 16;
    localparam int h_sync = 96;
    localparam int h_back = 48;
    localparam int h_total = h_active + h_front + h_sync + h_back;

    // Vertical timing in lines
    localparam int v_active = 480;
    localparam int v_front = 10;
    localparam int v_sync = 2;
    localparam int v_back = 33;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    // 400 picture lines centred in the 480 active lines
    localparam int border_lines = 40;

    // Text mode cells per row
    localparam int text_cols = 80;

    // Graphics mode layout, odd lines live in the upper half of the buffer
    localparam int gfx_line_words = 40;
    localparam int gfx_odd_base = 4096;

    // Frame buffer window at B8000, selected by address bits 19..14
    localparam logic [5:0] fb_base = 6'b101110;

    // Register window, four words starting at byte 3D0
    localparam logic [19:0] reg_base = 20'h003d0;

    // Register index, taken from address bits 2..1
    typedef enum logic [1:0] {
        // bit0 graphics enable, bit1 cursor enable
        reg_mode = 2'd0,
        // Cell index of the hardware cursor
        reg_cursor_pos = 2'd1,
        // Start scan row in bits 2..0, end scan row in bits 10..8
        reg_cursor_shape = 2'd2,
        // Background colour, palette set and intensity
        reg_palette = 2'd3
    } reg_index_e;

endpackage

// ==== logic/display_regs.sv ====
// CPU bus decode with the mode, cursor and palette registers and the access acknowledge
`timescale 1ns/100ps

module display_regs (
    input logic clk,
    input logic rst_n,
    input logic cpu_access,
    input logic [19:1] cpu_addr,
    input logic cpu_wr_en,
    input logic [15:0] cpu_wdata,
    input logic [1:0] cpu_bytesel,
    output logic cpu_ack,
    output logic [15:0] cpu_rdata,
    cpu_bus_if.host fb,
    output logic graphics_enabled,
    output logic cursor_enabled,
    output logic [10:0] cursor_pos,
    output logic [2:0] cursor_scan_start,
    output logic [2:0] cursor_scan_end,
    output logic [3:0] palette_bg,
    output logic palette_set,
    output logic palette_intensity
);

    logic fb_hit;
    logic reg_hit;
    logic reg_wr;
    display_pkg::reg_index_e reg_idx;
    logic [15:0] reg_value;
    logic [15:0] reg_rdata_q;
    logic rd_from_fb;

    assign fb_hit = cpu_addr[19:14] == display_pkg::fb_base;
    assign reg_hit = cpu_addr[19:3] == display_pkg::reg_base[19:3];
    assign reg_idx = display_pkg::reg_index_e'(cpu_addr[2:1]);
    assign reg_wr = cpu_access && reg_hit && cpu_wr_en;

    // Video memory accesses go straight through to the frame buffer
    assign fb.sel = cpu_access && fb_hit;
    assign fb.addr = cpu_addr[13:1];
    assign fb.wr_en = cpu_wr_en;
    assign fb.wdata = cpu_wdata;
    assign fb.bytesel = cpu_bytesel;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            graphics_enabled <= 1'b0;
            cursor_enabled <= 1'b0;
            cursor_pos <= '0;
            cursor_scan_start <= '0;
            cursor_scan_end <= '0;
            palette_bg <= '0;
            palette_set <= 1'b0;
            palette_intensity <= 1'b0;
        end else if (reg_wr) begin
            case (reg_idx)
                display_pkg::reg_mode: begin
                    if (cpu_bytesel[0])
                        {cursor_enabled, graphics_enabled} <= cpu_wdata[1:0];
                end
                display_pkg::reg_cursor_pos: begin
                    if (cpu_bytesel[0])
                        cursor_pos[7:0] <= cpu_wdata[7:0];
                    if (cpu_bytesel[1])
                        cursor_pos[10:8] <= cpu_wdata[10:8];
                end
                display_pkg::reg_cursor_shape: begin
                    if (cpu_bytesel[0])
                        cursor_scan_start <= cpu_wdata[2:0];
                    if (cpu_bytesel[1])
                        cursor_scan_end <= cpu_wdata[10:8];
                end
                default: begin
                    if (cpu_bytesel[0])
                        {palette_intensity, palette_set, palette_bg} <= cpu_wdata[5:0];
                end
            endcase
        end
    end

    always_comb begin
        case (reg_idx)
            display_pkg::reg_mode:
                reg_value = {14'b0, cursor_enabled, graphics_enabled};
            display_pkg::reg_cursor_pos:
                reg_value = {5'b0, cursor_pos};
            display_pkg::reg_cursor_shape:
                reg_value = {5'b0, cursor_scan_end, 5'b0, cursor_scan_start};
            default:
                reg_value = {10'b0, palette_intensity, palette_set, palette_bg};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_ack <= 1'b0;
            rd_from_fb <= 1'b0;
        end else begin
            // Every access is acknowledged, mapped or not
            cpu_ack <= cpu_access;
            rd_from_fb <= cpu_access && fb_hit && !cpu_wr_en;
        end
    end

    // Zero for writes, unmapped reads and idle cycles
    always_ff @(posedge clk)
        reg_rdata_q <= (cpu_access && reg_hit && !cpu_wr_en) ? reg_value : 16'h0000;

    assign cpu_rdata = rd_from_fb ? fb.rdata : reg_rdata_q;

    // Read data only appears in the acknowledge cycle
    rdata_only_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !cpu_ack |-> cpu_rdata == 16'h0000);

endmodule

// ==== logic/display_timing.sv ====
// 640x480 raster counters producing syncs, blanking, border and picture position
`timescale 1ns/100ps

module display_timing (
    input logic clk,
    input logic rst_n,
    scan_if.source scan
);

    logic [9:0] h_count;
    logic [9:0] v_count;
    logic line_end;
    logic active_line;

    assign line_end = h_count == 10'(display_pkg::h_total - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            h_count <= line_end ? '0 : h_count + 10'd1;
            if (line_end) begin
                if (v_count == 10'(display_pkg::v_total - 1))
                    v_count <= '0;
                else
                    v_count <= v_count + 10'd1;
            end
        end
    end

    assign active_line = v_count < 10'(display_pkg::v_active);

    // Syncs are low during the pulse
    assign scan.hsync = !(h_count >= 10'(display_pkg::h_active + display_pkg::h_front) &&
        h_count < 10'(display_pkg::h_active + display_pkg::h_front + display_pkg::h_sync));
    assign scan.vsync = !(v_count >= 10'(display_pkg::v_active + display_pkg::v_front) &&
        v_count < 10'(display_pkg::v_active + display_pkg::v_front + display_pkg::v_sync));

    assign scan.is_blank = !active_line || h_count >= 10'(display_pkg::h_active);
    assign scan.is_border = active_line &&
        (v_count < 10'(display_pkg::border_lines) ||
         v_count >= 10'(display_pkg::v_active - display_pkg::border_lines));

    // Row wraps on the top border, those lines are masked downstream
    assign scan.row = v_count - 10'(display_pkg::border_lines);
    assign scan.col = h_count;

    col_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        h_count < 10'(display_pkg::h_total));

endmodule

// ==== logic/display_top.sv ====
// Display block top level, CPU bus and video outputs on plain ports
`timescale 1ns/100ps

module display_top (
    input logic clk,
    input logic rst_n,
    input logic cpu_access,
    input logic [19:1] cpu_addr,
    input logic cpu_wr_en,
    input logic [15:0] cpu_wdata,
    input logic [1:0] cpu_bytesel,
    output logic cpu_ack,
    output logic [15:0] cpu_rdata,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic [7:0] glyph,
    output logic [3:0] foreground,
    output logic [3:0] background,
    output logic render_cursor,
    output logic [3:0] colour
);

    logic graphics_enabled;
    logic cursor_enabled;
    logic [10:0] cursor_pos;
    logic [2:0] cursor_scan_start;
    logic [2:0] cursor_scan_end;
    logic [3:0] palette_bg;
    logic palette_set;
    logic palette_intensity;
    logic [7:0] fb_glyph;
    logic [3:0] fb_foreground;
    logic [3:0] fb_background;
    logic fb_cursor;
    logic [1:0] graphics_colour;

    cpu_bus_if fb_bus ();
    scan_if scan ();

    display_timing display_timing_inst (
        .clk(clk),
        .rst_n(rst_n),
        .scan(scan.source)
    );

    display_regs display_regs_inst (
        .clk(clk),
        .rst_n(rst_n),
        .cpu_access(cpu_access),
        .cpu_addr(cpu_addr),
        .cpu_wr_en(cpu_wr_en),
        .cpu_wdata(cpu_wdata),
        .cpu_bytesel(cpu_bytesel),
        .cpu_ack(cpu_ack),
        .cpu_rdata(cpu_rdata),
        .fb(fb_bus.host),
        .graphics_enabled(graphics_enabled),
        .cursor_enabled(cursor_enabled),
        .cursor_pos(cursor_pos),
        .cursor_scan_start(cursor_scan_start),
        .cursor_scan_end(cursor_scan_end),
        .palette_bg(palette_bg),
        .palette_set(palette_set),
        .palette_intensity(palette_intensity)
    );

    frame_buffer frame_buffer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .cpu(fb_bus.ram),
        .scan(scan.sink),
        .graphics_enabled(graphics_enabled),
        .cursor_enabled(cursor_enabled),
        .cursor_pos(cursor_pos),
        .cursor_scan_start(cursor_scan_start),
        .cursor_scan_end(cursor_scan_end),
        .glyph(fb_glyph),
        .foreground(fb_foreground),
        .background(fb_background),
        .render_cursor(fb_cursor),
        .graphics_colour(graphics_colour)
    );

    pixel_out pixel_out_inst (
        .clk(clk),
        .rst_n(rst_n),
        .scan(scan.sink),
        .graphics_enabled(graphics_enabled),
        .graphics_colour(graphics_colour),
        .palette_bg(palette_bg),
        .palette_set(palette_set),
        .palette_intensity(palette_intensity),
        .glyph_in(fb_glyph),
        .foreground_in(fb_foreground),
        .background_in(fb_background),
        .cursor_in(fb_cursor),
        .glyph(glyph),
        .foreground(foreground),
        .background(background),
        .render_cursor(render_cursor),
        .hsync(hsync),
        .vsync(vsync),
        .de(de),
        .colour(colour)
    );

endmodule

// ==== logic/frame_buffer.sv ====
// Video RAM wrapper with scan address generation, cursor match and pixel selection
`timescale 1ns/100ps

module frame_buffer (
    input logic clk,
    input logic rst_n,
    cpu_bus_if.ram cpu,
    scan_if.sink scan,
    input logic graphics_enabled,
    input logic cursor_enabled,
    input logic [10:0] cursor_pos,
    input logic [2:0] cursor_scan_start,
    input logic [2:0] cursor_scan_end,
    output logic [7:0] glyph,
    output logic [3:0] foreground,
    output logic [3:0] background,
    output logic render_cursor,
    output logic [1:0] graphics_colour
);

    logic [12:0] text_cell;
    logic [12:0] gfx_word;
    logic [12:0] scan_addr;
    logic [2:0] glyph_row;
    logic [15:0] scan_q;
    logic scan_valid;
    logic [2:0] pixel_offs;
    logic [3:0] pixel_shift;

    // Cells are 8x16 pixels
    assign text_cell = 13'(scan.row[9:4]) * 13'(display_pkg::text_cols) +
        13'(scan.col[9:3]);

    // Pixels are doubled both ways, odd graphics lines sit at the upper half
    always_comb begin
        gfx_word = 13'(scan.row[9:2]) * 13'(display_pkg::gfx_line_words) +
            13'(scan.col[9:4]);
        if (scan.row[1])
            gfx_word = gfx_word + 13'(display_pkg::gfx_odd_base);
    end

    assign scan_addr = graphics_enabled ? gfx_word : text_cell;
    assign glyph_row = scan.row[3:1];

    frame_ram frame_ram_inst (
        .clk(clk),
        .a_addr(cpu.addr),
        .a_bytesel(cpu.bytesel),
        .a_wdata(cpu.wdata),
        .a_wr_en(cpu.sel && cpu.wr_en),
        .a_rdata(cpu.rdata),
        .b_addr(scan_addr),
        .b_rdata(scan_q)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_valid <= 1'b0;
            pixel_offs <= '0;
            render_cursor <= 1'b0;
        end else begin
            scan_valid <= !scan.is_blank && !scan.is_border;
            pixel_offs <= scan.col[3:1];
            // Border rows wrap the row count, so they must not match a cell
            render_cursor <= !scan.is_blank && !scan.is_border && cursor_enabled &&
                text_cell == 13'(cursor_pos) &&
                glyph_row >= cursor_scan_start && glyph_row <= cursor_scan_end;
        end
    end

    // Attribute byte is background in the top nibble, foreground below
    assign {background, foreground, glyph} = scan_valid ? scan_q : 16'h0000;

    // CGA order: low byte first, highest pair first within each byte
    assign pixel_shift = {pixel_offs[2], ~pixel_offs[1:0], 1'b0};
    assign graphics_colour = scan_valid ? scan_q[pixel_shift +: 2] : 2'b00;

endmodule

// ==== logic/frame_ram.sv ====
// 8K x 16 dual-port video RAM with a byte-writable CPU port and a read-only scan port
`timescale 1ns/100ps

module frame_ram (
    input logic clk,
    input logic [12:0] a_addr,
    input logic [1:0] a_bytesel,
    input logic [15:0] a_wdata,
    input logic a_wr_en,
    output logic [15:0] a_rdata,
    input logic [12:0] b_addr,
    output logic [15:0] b_rdata
);

    logic [15:0] mem [8192];

    // Port a, read returns the old contents on a write
    always_ff @(posedge clk) begin
        if (a_wr_en && a_bytesel[0])
            mem[a_addr][7:0] <= a_wdata[7:0];
        if (a_wr_en && a_bytesel[1])
            mem[a_addr][15:8] <= a_wdata[15:8];
        a_rdata <= mem[a_addr];
    end

    // Port b for the raster scan
    always_ff @(posedge clk)
        b_rdata <= mem[b_addr];

endmodule

// ==== logic/pixel_out.sv ====
// Output stage with palette lookup, aligning syncs and blanking to the pixel data
`timescale 1ns/100ps

module pixel_out (
    input logic clk,
    input logic rst_n,
    scan_if.sink scan,
    input logic graphics_enabled,
    input logic [1:0] graphics_colour,
    input logic [3:0] palette_bg,
    input logic palette_set,
    input logic palette_intensity,
    input logic [7:0] glyph_in,
    input logic [3:0] foreground_in,
    input logic [3:0] background_in,
    input logic cursor_in,
    output logic [7:0] glyph,
    output logic [3:0] foreground,
    output logic [3:0] background,
    output logic render_cursor,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic [3:0] colour
);

    logic hsync_s1;
    logic vsync_s1;
    logic de_s1;
    logic [3:0] mapped;

    // Pixel 0 shows the background and 1..3 pick from the selected palette set
    assign mapped = graphics_colour == 2'b00 ? palette_bg :
        {palette_intensity, graphics_colour, palette_set};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync_s1 <= 1'b1;
            vsync_s1 <= 1'b1;
            de_s1 <= 1'b0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de <= 1'b0;
            glyph <= '0;
            foreground <= '0;
            background <= '0;
            render_cursor <= 1'b0;
            colour <= '0;
        end else begin
            hsync_s1 <= scan.hsync;
            vsync_s1 <= scan.vsync;
            de_s1 <= !scan.is_blank;
            hsync <= hsync_s1;
            vsync <= vsync_s1;
            de <= de_s1;
            glyph <= glyph_in;
            foreground <= foreground_in;
            background <= background_in;
            render_cursor <= cursor_in;
            // Border shows the background colour and blanking shows black
            colour <= (graphics_enabled && de_s1) ? mapped : 4'h0;
        end
    end

    // Sync pulses sit inside the blanking interval
    sync_in_blanking: assert property (@(posedge clk) disable iff (!rst_n)
        de |-> hsync && vsync);

endmodule

// ==== logic/scan_if.sv ====
// Raster position and blanking flags broadcast by the timing generator
`timescale 1ns/100ps

interface scan_if;

    // Position relative to the top left of the picture
    logic [9:0] row;
    logic [9:0] col;
    // Active low syncs
    logic hsync;
    logic vsync;
    // Outside the 640x480 active area
    logic is_blank;
    // Active lines above or below the picture
    logic is_border;

    modport source (
        output row, col, hsync, vsync, is_blank, is_border
    );

    modport sink (
        input row, col, hsync, vsync, is_blank, is_border
    );

endinterface

// ==== verif/display_top_tb.sv ====
// Testbench for display_top, run as the simulation top with the project file list
`timescale 1ns/100ps

module display_top_tb;

    typedef struct packed {
        logic [19:0] byte_addr;
        logic wr;
        logic [15:0] data;
        logic [1:0] be;
        logic [15:0] exp_rdata;
    } step_t;

    logic clk;
    logic rst_n;
    logic cpu_access;
    logic [19:1] cpu_addr;
    logic cpu_wr_en;
    logic [15:0] cpu_wdata;
    logic [1:0] cpu_bytesel;
    logic cpu_ack;
    logic [15:0] cpu_rdata;
    logic hsync;
    logic vsync;
    logic de;
    logic [7:0] glyph;
    logic [3:0] foreground;
    logic [3:0] background;
    logic render_cursor;
    logic [3:0] colour;

    step_t steps[$];
    logic [15:0] shadow [8192];
    logic [31:0] rnd_state;
    int errors;
    int checks;
    int probe_lines[9] = '{5, 40, 41, 57, 123, 250, 439, 440, 470};
    int probe_cols[4] = '{0, 9, 317, 639};

    // Screen position of the aligned outputs
    int cur_line;
    int cur_col;
    logic cur_de;

    always #10 clk = ~clk;

    display_top display_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .cpu_access(cpu_access),
        .cpu_addr(cpu_addr),
        .cpu_wr_en(cpu_wr_en),
        .cpu_wdata(cpu_wdata),
        .cpu_bytesel(cpu_bytesel),
        .cpu_ack(cpu_ack),
        .cpu_rdata(cpu_rdata),
        .hsync(hsync),
        .vsync(vsync),
        .de(de),
        .glyph(glyph),
        .foreground(foreground),
        .background(background),
        .render_cursor(render_cursor),
        .colour(colour)
    );

    // Line restarts at vsync and column restarts at each rising de
    always @(negedge clk) begin
        if (!rst_n) begin
            cur_line = -1;
            cur_col = 0;
            cur_de = 1'b0;
        end else begin
            if (!vsync)
                cur_line = -1;
            if (de && !cur_de) begin
                cur_line = cur_line + 1;
                cur_col = 0;
            end else if (de) begin
                cur_col = cur_col + 1;
            end
            cur_de = de;
        end
    end

    function automatic logic [31:0] next_random();
        rnd_state = rnd_state ^ (rnd_state << 13);
        rnd_state = rnd_state ^ (rnd_state >> 17);
        rnd_state = rnd_state ^ (rnd_state << 5);
        return rnd_state;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error: %s at %0t", what, $time);
    endtask

    // Strobe for one cycle, then wait for the acknowledge and count its latency
    task automatic bus_cycle(input logic [19:0] byte_addr, input logic wr,
                             input logic [15:0] data, input logic [1:0] be,
                             output logic [15:0] rdata);
        int cycles;
        @(posedge clk);
        #2;
        cpu_access = 1'b1;
        cpu_addr = byte_addr[19:1];
        cpu_wr_en = wr;
        cpu_wdata = data;
        cpu_bytesel = be;
        @(posedge clk);
        #2;
        cpu_access = 1'b0;
        cpu_wr_en = 1'b0;
        cycles = 0;
        rdata = 16'h0000;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cpu_ack && cycles < 8);
        if (!cpu_ack) begin
            report_failure("no acknowledge for a CPU access");
        end else begin
            compare("ack latency", 32'(cycles), 32'd1);
            rdata = cpu_rdata;
            // Acknowledge lasts one cycle and read data drops with it
            @(negedge clk);
            compare("cpu_ack", 32'(cpu_ack), 32'd0);
            compare("cpu_rdata", 32'(cpu_rdata), 32'd0);
        end
    endtask

    task automatic fb_write(input int word, input logic [15:0] data, input logic [1:0] be);
        logic [15:0] unused;
        bus_cycle(20'hb8000 + 20'(word * 2), 1'b1, data, be, unused);
        if (be[0])
            shadow[word][7:0] = data[7:0];
        if (be[1])
            shadow[word][15:8] = data[15:8];
    endtask

    task automatic set_reg(input logic [19:0] byte_addr, input logic [15:0] data);
        logic [15:0] unused;
        bus_cycle(byte_addr, 1'b1, data, 2'b11, unused);
    endtask

    task automatic wait_pixel(input int line, input int col, output bit found);
        int n;
        found = 0;
        n = 0;
        while (!found && n < 900000) begin
            @(negedge clk);
            #1;
            n++;
            if (cur_de && cur_line == line && cur_col == col)
                found = 1;
        end
        if (!found)
            report_failure($sformatf("timeout waiting for line %0d column %0d", line, col));
    endtask

    function automatic logic [15:0] text_expect(input int line, input int col);
        int r;
        if (line < 40 || line >= 440)
            return 16'h0000;
        r = line - 40;
        return shadow[(r / 16) * 80 + col / 8];
    endfunction

    // Pixel 0 of a word sits in bits 7..6 and pixel 4 in bits 15..14
    function automatic logic [3:0] gfx_expect(input int line, input int col,
                                              input logic [5:0] pal);
        int r;
        int w;
        int p;
        int v;
        int c;
        logic [7:0] b;
        if (line < 40 || line >= 440)
            return pal[3:0];
        r = line - 40;
        w = (r / 4) * 40 + col / 16 + ((r % 4) >= 2 ? 4096 : 0);
        p = (col % 16) / 2;
        b = p < 4 ? shadow[w][7:0] : shadow[w][15:8];
        v = (32'(b) >> (6 - 2 * (p % 4))) & 3;
        if (v == 0)
            return pal[3:0];
        c = 2 * v + 32'(pal[4]) + (pal[5] ? 8 : 0);
        return 4'(c);
    endfunction

    task automatic check_text();
        bit found;
        logic [15:0] exp;
        foreach (probe_lines[i]) begin
            foreach (probe_cols[j]) begin
                wait_pixel(probe_lines[i], probe_cols[j], found);
                if (found) begin
                    exp = text_expect(probe_lines[i], probe_cols[j]);
                    compare("glyph", 32'(glyph), 32'(exp[7:0]));
                    compare("foreground", 32'(foreground), 32'(exp[11:8]));
                    compare("background", 32'(background), 32'(exp[15:12]));
                    compare("render_cursor", 32'(render_cursor), 32'd0);
                    compare("colour", 32'(colour), 32'd0);
                end
            end
        end
    endtask

    // Cursor on cell 833 covers picture rows 160..175 and columns 264..271
    task automatic check_cursor();
        bit found;
        bit exp;
        int cols[4] = '{263, 264, 271, 272};
        set_reg(20'h003d2, 16'd833);
        set_reg(20'h003d4, 16'h0502);
        set_reg(20'h003d0, 16'h0002);
        for (int r = 158; r < 178; r++) begin
            foreach (cols[j]) begin
                wait_pixel(r + 40, cols[j], found);
                exp = r >= 160 && r < 176 && ((r % 16) / 2) >= 2 && ((r % 16) / 2) <= 5 &&
                    cols[j] >= 264 && cols[j] < 272;
                if (found)
                    compare("render_cursor", 32'(render_cursor), 32'(exp));
            end
        end
        set_reg(20'h003d0, 16'h0000);
        wait_pixel(208, 266, found);
        if (found)
            compare("render_cursor", 32'(render_cursor), 32'd0);
    endtask

    task automatic check_graphics(input logic [5:0] pal);
        bit found;
        set_reg(20'h003d6, 16'(pal));
        set_reg(20'h003d0, 16'h0001);
        foreach (probe_lines[i]) begin
            foreach (probe_cols[j]) begin
                wait_pixel(probe_lines[i], probe_cols[j], found);
                if (found)
                    compare("colour", 32'(colour),
                        32'(gfx_expect(probe_lines[i], probe_cols[j], pal)));
            end
        end
    endtask

    // One full frame between two vsync pulses
    task automatic check_timing();
        int n;
        int last_fall;
        int de_run;
        int de_lines;
        int vs_falls;
        int blank_bad;
        logic hs_p;
        logic vs_p;
        logic de_p;
        n = 0;
        last_fall = -1;
        de_run = 0;
        de_lines = 0;
        vs_falls = 0;
        blank_bad = 0;
        hs_p = 1'b1;
        vs_p = 1'b1;
        de_p = 1'b0;
        while (vs_falls < 2 && n < 900000) begin
            @(negedge clk);
            #1;
            n++;
            if (!hsync && hs_p) begin
                if (last_fall >= 0)
                    compare("hsync period", 32'(n - last_fall), 32'd800);
                last_fall = n;
            end
            if (!vsync && vs_p) begin
                if (vs_falls == 1)
                    compare("de lines per frame", 32'(de_lines), 32'd480);
                vs_falls++;
                de_lines = 0;
            end
            if (de && !de_p)
                de_lines++;
            if (de)
                de_run++;
            else if (de_p) begin
                compare("de length", 32'(de_run), 32'd640);
                de_run = 0;
            end
            if (!de && (glyph != 8'h00 || foreground != 4'h0 || background != 4'h0 ||
                    colour != 4'h0 || render_cursor))
                blank_bad++;
            hs_p = hsync;
            vs_p = vsync;
            de_p = de;
        end
        if (vs_falls < 2)
            report_failure("timeout waiting for two vsync pulses");
        if (blank_bad != 0)
            report_failure($sformatf("%0d blanked cycles with nonzero video outputs", blank_bad));
    endtask

    initial begin
        logic [15:0] rd;
        logic [31:0] rv;
        int word;
        clk = 1'b0;
        rst_n = 1'b0;
        cpu_access = 1'b0;
        cpu_addr = '0;
        cpu_wr_en = 1'b0;
        cpu_wdata = '0;
        cpu_bytesel = 2'b00;
        rnd_state = 32'h9a65e23e;
        errors = 0;
        checks = 0;

        // Address, write, data, byte enables, expected read data
        steps.push_back('{20'h003d0, 1'b0, 16'h0000, 2'b11, 16'h0000});
        steps.push_back('{20'h003d2, 1'b0, 16'h0000, 2'b11, 16'h0000});
        steps.push_back('{20'h003d4, 1'b0, 16'h0000, 2'b11, 16'h0000});
        steps.push_back('{20'h003d6, 1'b0, 16'h0000, 2'b11, 16'h0000});
        steps.push_back('{20'h003d2, 1'b1, 16'h07ff, 2'b11, 16'h0000});
        steps.push_back('{20'h003d2, 1'b0, 16'h0000, 2'b11, 16'h07ff});
        steps.push_back('{20'h003d2, 1'b1, 16'h1234, 2'b01, 16'h0000});
        steps.push_back('{20'h003d2, 1'b0, 16'h0000, 2'b11, 16'h0734});
        steps.push_back('{20'h003d4, 1'b1, 16'hffff, 2'b01, 16'h0000});
        steps.push_back('{20'h003d4, 1'b0, 16'h0000, 2'b11, 16'h0007});
        steps.push_back('{20'h003d4, 1'b1, 16'h0d00, 2'b10, 16'h0000});
        steps.push_back('{20'h003d4, 1'b0, 16'h0000, 2'b11, 16'h0507});
        steps.push_back('{20'h003d6, 1'b1, 16'h00ff, 2'b10, 16'h0000});
        steps.push_back('{20'h003d6, 1'b0, 16'h0000, 2'b11, 16'h0000});
        steps.push_back('{20'h003d6, 1'b1, 16'h003f, 2'b01, 16'h0000});
        steps.push_back('{20'h003d6, 1'b0, 16'h0000, 2'b11, 16'h003f});
        steps.push_back('{20'h003d0, 1'b1, 16'h0003, 2'b11, 16'h0000});
        steps.push_back('{20'h003d0, 1'b0, 16'h0000, 2'b11, 16'h0003});
        steps.push_back('{20'h00000, 1'b0, 16'h0000, 2'b11, 16'h0000});
        steps.push_back('{20'h003d8, 1'b0, 16'h0000, 2'b11, 16'h0000});
        steps.push_back('{20'hb8000, 1'b1, 16'h1234, 2'b11, 16'h0000});
        steps.push_back('{20'hb8000, 1'b0, 16'h0000, 2'b11, 16'h1234});
        steps.push_back('{20'hb8000, 1'b1, 16'habcd, 2'b10, 16'h0000});
        steps.push_back('{20'hb8000, 1'b0, 16'h0000, 2'b11, 16'hab34});
        steps.push_back('{20'hb8000, 1'b1, 16'h5566, 2'b01, 16'h0000});
        steps.push_back('{20'hb8000, 1'b0, 16'h0000, 2'b11, 16'hab66});
        // Unmapped address that aliases video word 0 in its low bits
        steps.push_back('{20'h10000, 1'b1, 16'hbeef, 2'b11, 16'h0000});
        steps.push_back('{20'h10000, 1'b0, 16'h0000, 2'b11, 16'h0000});
        steps.push_back('{20'hb8000, 1'b0, 16'h0000, 2'b11, 16'hab66});
        // Back to text mode with everything off
        steps.push_back('{20'h003d0, 1'b1, 16'h0000, 2'b11, 16'h0000});
        steps.push_back('{20'h003d2, 1'b1, 16'h0000, 2'b11, 16'h0000});
        steps.push_back('{20'h003d4, 1'b1, 16'h0000, 2'b11, 16'h0000});
        steps.push_back('{20'h003d6, 1'b1, 16'h0000, 2'b11, 16'h0000});

        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        foreach (steps[i]) begin
            bus_cycle(steps[i].byte_addr, steps[i].wr, steps[i].data, steps[i].be, rd);
            compare($sformatf("cpu_rdata step %0d", i), 32'(rd), 32'(steps[i].exp_rdata));
        end

        for (int a = 0; a < 8192; a++) begin
            rv = next_random();
            fb_write(a, rv[15:0], 2'b11);
        end

        // Partial writes followed by a readback of the merged word
        for (int k = 0; k < 48; k++) begin
            rv = next_random();
            word = 32'(rv[12:0]);
            fb_write(word, rv[31:16], 2'(32'(rv[14:13]) % 3 + 1));
            bus_cycle(20'hb8000 + 20'(word * 2), 1'b0, 16'h0000, 2'b11, rd);
            compare("cpu_rdata readback", 32'(rd), 32'(shadow[word]));
        end

        check_text();
        check_cursor();
        check_graphics(6'h05);
        check_graphics(6'h3a);
        check_timing();

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
